//--- flist.f
logic/frontend_pkg.sv
logic/fetch_stage.sv
logic/inst_rom.sv
logic/reg_file.sv
logic/branch_unit.sv
logic/decode_stage.sv
logic/frontend_top.sv
testbench/frontend_tb.sv

//--- program.hex
// one 32-bit instruction word per line, hex, word 0 at address 0x8000_0000
00100293 // 0x00 addi x5,x0,1
00200313 // 0x04 addi x6,x0,2
00208463 // 0x08 beq x1,x2,+8
00300393 // 0x0c wrong path
00209463 // 0x10 bne x1,x2,+8
0011c463 // 0x14 blt x3,x1,+8
00600413 // 0x18 wrong path
0080006f // 0x1c jal x0,+8
00800493 // 0x20 wrong path
00020067 // 0x24 jalr x0,0(x4)
00000013
00000013
00000013
00000013
00000013
00000013
00208463 // 0x40 beq x1,x2,+8 after x1 is rewritten
00400493 // 0x44 addi x9,x0,4
00500513 // 0x48 addi x10,x0,5
0000006f // 0x4c jal x0,0

//--- testbench/frontend_tb.sv
module frontend_tb
    import frontend_pkg::*;
();

    localparam int              max_entries  = 32;
    localparam logic [xlen-1:0] collision_pc = 64'h0000_0000_8000_0040;

    logic                  clk;
    logic                  rst;
    logic                  stall;
    logic                  wb_en;
    logic [4:0]            wb_addr;
    logic [xlen-1:0]       wb_data;
    logic                  ds_to_es_valid;
    logic [xlen-1:0]       ds_pc;
    logic [inst_width-1:0] ds_inst;
    logic [xlen-1:0]       ds_rs1_value;
    logic [xlen-1:0]       ds_rs2_value;

    // expected issue sequence
    string                 name_tab [max_entries];
    logic [xlen-1:0]       pc_tab   [max_entries];
    logic [inst_width-1:0] inst_tab [max_entries];
    logic [xlen-1:0]       rs1_tab  [max_entries];
    logic [xlen-1:0]       rs2_tab  [max_entries];
    int                    n_entries   = 0;
    int                    matched     = 0;
    int                    cycle_count = 0;
    integer                seed;
    logic                  collided;

    frontend_top frontend_top_i (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_pc          (ds_pc),
        .ds_inst        (ds_inst),
        .ds_rs1_value   (ds_rs1_value),
        .ds_rs2_value   (ds_rs2_value)
    );

    task automatic add_entry(input string name, input logic [xlen-1:0] pc,
                             input logic [inst_width-1:0] inst, input logic [xlen-1:0] rs1,
                             input logic [xlen-1:0] rs2);
        name_tab[n_entries] = name;
        pc_tab[n_entries]   = pc;
        inst_tab[n_entries] = inst;
        rs1_tab[n_entries]  = rs1;
        rs2_tab[n_entries]  = rs2;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry("straight_0",      64'h8000_0000, 32'h0010_0293, 64'd0, 64'd5);
        add_entry("straight_1",      64'h8000_0004, 32'h0020_0313, 64'd0, 64'd5);
        add_entry("beq_taken",       64'h8000_0008, 32'h0020_8463, 64'd5, 64'd5);
        add_entry("beq_squash",      64'd0,         nop_inst,      64'd0, 64'd0);
        add_entry("bne_not_taken",   64'h8000_0010, 32'h0020_9463, 64'd5, 64'd5);
        add_entry("blt_taken",       64'h8000_0014, 32'h0011_c463, 64'hffff_ffff_ffff_fffd,
                  64'd5);
        add_entry("blt_squash",      64'd0,         nop_inst,      64'd0, 64'd0);
        add_entry("jal_forward",     64'h8000_001c, 32'h0080_006f, 64'd0, 64'd34);
        add_entry("jal_squash",      64'd0,         nop_inst,      64'd0, 64'd0);
        add_entry("jalr_x4",         64'h8000_0024, 32'h0002_0067, 64'h8000_0040, 64'd0);
        add_entry("jalr_squash",     64'd0,         nop_inst,      64'd0, 64'd0);
        // x1 is 7 by now so the branch falls through
        add_entry("beq_after_write", 64'h8000_0040, 32'h0020_8463, 64'd7, 64'd5);
        add_entry("post_branch_0",   64'h8000_0044, 32'h0040_0493, 64'd0, 64'h8000_0040);
        add_entry("post_branch_1",   64'h8000_0048, 32'h0050_0513, 64'd0, 64'd21);
        add_entry("jal_self",        64'h8000_004c, 32'h0000_006f, 64'd0, 64'd0);
        add_entry("jal_self_squash", 64'd0,         nop_inst,      64'd0, 64'd0);
        add_entry("jal_self_repeat", 64'h8000_004c, 32'h0000_006f, 64'd0, 64'd0);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one register write, then on to the next drive point
    task automatic write_reg(input logic [4:0] addr, input logic [xlen-1:0] value);
        wb_en   = 1'b1;
        wb_addr = addr;
        wb_data = value;
        @(posedge clk);
        #10;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst      = 1'b1;
        stall    = 1'b0;
        wb_en    = 1'b0;
        wb_addr  = 5'd0;
        wb_data  = '0;
        seed     = 32'hf86d;
        collided = 1'b0;
        write_reg(5'd1, 64'd5); // two reset edges
        write_reg(5'd2, 64'd5);
        rst = 1'b0;
        write_reg(5'd3, 64'hffff_ffff_ffff_fffd); // done long before the first branch
        write_reg(5'd4, 64'h0000_0000_8000_0040);
        write_reg(5'd5, 64'd21); // read through rs2 fields of later words
        write_reg(5'd8, 64'd34);
        wb_en = 1'b0;
        forever begin
            stall = (($random(seed) & 3) == 0); // roughly one cycle in four
            if (!collided && ds_pc == collision_pc) begin
                // beq x1,x2 just entered decode, rewrite x1 under it
                wb_en    = 1'b1;
                wb_addr  = 5'd1;
                wb_data  = 64'd7;
                collided = 1'b1;
                #20;
                check_value("beq_write_hold", "valid", 64'd0, {63'd0, ds_to_es_valid});
            end else begin
                wb_en = 1'b0;
            end
            @(posedge clk);
            #10;
        end
    end

    initial begin
        build_table();
        while (matched < n_entries) begin
            @(negedge clk);
            if (ds_to_es_valid && !stall) begin // issues at the coming edge
                check_value(name_tab[matched], "pc", pc_tab[matched], ds_pc);
                check_value(name_tab[matched], "inst", inst_tab[matched], ds_inst);
                check_value(name_tab[matched], "rs1", rs1_tab[matched], ds_rs1_value);
                check_value(name_tab[matched], "rs2", rs2_tab[matched], ds_rs2_value);
                matched++;
            end
        end
        $display("Regression passed");
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycle_count < n_entries * 8 + 20) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("issue sequence did not complete: %0d of %0d entries after %0d cycles",
                 matched, n_entries, cycle_count);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

//--- logic/frontend_top.sv
module frontend_top
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  wb_en,
    input  logic [4:0]            wb_addr,
    input  logic [xlen-1:0]       wb_data,
    output logic                  ds_to_es_valid,
    output logic [xlen-1:0]       ds_pc,
    output logic [inst_width-1:0] ds_inst,
    output logic [xlen-1:0]       ds_rs1_value,
    output logic [xlen-1:0]       ds_rs2_value
);

    logic                  es_allowin;
    logic                  ds_allowin;
    logic                  fs_to_ds_valid;
    logic [inst_width-1:0] fs_inst;
    logic [xlen-1:0]       fs_pc;
    logic [xlen-1:0]       br_alu_target;
    logic [1:0]            br_pc_sel;
    logic                  br_taken;
    logic [xlen-1:0]       br_target;
    logic                  i_ram_en;
    logic [xlen-1:0]       inst_raddr;
    logic [inst_width-1:0] inst;

    assign es_allowin = ~stall; // downstream back-pressure

    fetch_stage fetch_stage_i (
        .clk            (clk),
        .rst            (rst),
        .ds_allowin     (ds_allowin),
        .br_alu_target  (br_alu_target),
        .br_pc_sel      (br_pc_sel),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .inst           (inst),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .i_ram_en       (i_ram_en),
        .inst_raddr     (inst_raddr)
    );

    inst_rom inst_rom_i (
        .clk  (clk),
        .en   (i_ram_en),
        .addr (inst_raddr),
        .data (inst)
    );

    decode_stage decode_stage_i (
        .clk            (clk),
        .rst            (rst),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .es_allowin     (es_allowin),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_pc          (ds_pc),
        .ds_inst        (ds_inst),
        .ds_rs1_value   (ds_rs1_value),
        .ds_rs2_value   (ds_rs2_value),
        .br_alu_target  (br_alu_target),
        .br_pc_sel      (br_pc_sel),
        .br_taken       (br_taken),
        .br_target      (br_target)
    );

endmodule

//--- logic/decode_stage.sv
module decode_stage
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fs_to_ds_valid,
    input  logic [inst_width-1:0] fs_inst,
    input  logic [xlen-1:0]       fs_pc,
    input  logic                  es_allowin,
    input  logic                  wb_en,
    input  logic [4:0]            wb_addr,
    input  logic [xlen-1:0]       wb_data,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output logic [xlen-1:0]       ds_pc,
    output logic [inst_width-1:0] ds_inst,
    output logic [xlen-1:0]       ds_rs1_value,
    output logic [xlen-1:0]       ds_rs2_value,
    output logic [xlen-1:0]       br_alu_target,
    output logic [1:0]            br_pc_sel,
    output logic                  br_taken,
    output logic [xlen-1:0]       br_target
);

    logic       ds_valid;
    logic       ds_ready_go;
    logic       fire;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [6:0] opcode;
    logic       is_branch;
    logic       is_jalr;
    logic       wb_live;
    logic       collision;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    assign opcode    = ds_inst[6:0];
    assign rs1_addr  = ds_inst[19:15];
    assign rs2_addr  = ds_inst[24:20];
    assign is_branch = (opcode == op_branch);
    assign is_jalr   = (opcode == op_jalr);

    // branch operands must not be read while the write port updates them
    assign wb_live   = wb_en && (wb_addr != 5'd0);
    assign collision = wb_live &&
                       ((is_branch && (wb_addr == rs1_addr || wb_addr == rs2_addr)) ||
                        (is_jalr && (wb_addr == rs1_addr)));

    assign ds_ready_go    = !collision;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;
    assign fire           = ds_valid && ds_ready_go && es_allowin; // once per instruction

    reg_file reg_file_i (
        .clk       (clk),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rs1_value (ds_rs1_value),
        .rs2_value (ds_rs2_value)
    );

    branch_unit branch_unit_i (
        .fire          (fire),
        .inst          (ds_inst),
        .pc            (ds_pc),
        .rs1_value     (ds_rs1_value),
        .rs2_value     (ds_rs2_value),
        .br_alu_target (br_alu_target),
        .br_pc_sel     (br_pc_sel),
        .br_taken      (br_taken),
        .br_target     (br_target)
    );

endmodule

//--- logic/branch_unit.sv
module branch_unit
    import frontend_pkg::*;
(
    input  logic                  fire,
    input  logic [inst_width-1:0] inst,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       rs1_value,
    input  logic [xlen-1:0]       rs2_value,
    output logic [xlen-1:0]       br_alu_target,
    output logic [1:0]            br_pc_sel,
    output logic                  br_taken,
    output logic [xlen-1:0]       br_target
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] jalr_sum;
    logic            eq;
    logic            lt;
    logic            cond_met;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign is_branch = (opcode == op_branch);
    assign is_jal    = (opcode == op_jal);
    assign is_jalr   = (opcode == op_jalr);

    // sign-extended immediates
    assign imm_b = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};

    assign eq = (rs1_value == rs2_value);
    assign lt = ($signed(rs1_value) < $signed(rs2_value));

    always_comb begin
        case (funct3)
            f3_beq:  cond_met = eq;
            f3_bne:  cond_met = !eq;
            f3_blt:  cond_met = lt;
            f3_bge:  cond_met = !lt;
            default: cond_met = 1'b0; // unsigned compares not supported
        endcase
    end

    assign jalr_sum      = rs1_value + imm_i;
    assign br_alu_target = {jalr_sum[xlen-1:1], 1'b0};
    assign br_target     = pc + (is_jal ? imm_j : imm_b);

    // select stays sequential unless decode actually fires
    always_comb begin
        if (!fire) begin
            br_pc_sel = pc_pc;
        end else if (is_jalr) begin
            br_pc_sel = pc_alu;
        end else if (is_branch || is_jal) begin
            br_pc_sel = blu_pc;
        end else begin
            br_pc_sel = pc_pc;
        end
    end

    assign br_taken = fire && (is_jal || is_jalr || (is_branch && cond_met));

endmodule

//--- logic/reg_file.sv
module reg_file
    import frontend_pkg::*;
(
    input  logic            clk,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic            wb_en,
    input  logic [4:0]      wb_addr,
    input  logic [xlen-1:0] wb_data,
    output logic [xlen-1:0] rs1_value,
    output logic [xlen-1:0] rs2_value
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (wb_en && (wb_addr != 5'd0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // x0 hardwired to zero, entry 0 never written
    assign rs1_value = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- logic/inst_rom.sv
module inst_rom
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  en,
    input  logic [xlen-1:0]       addr,
    output logic [inst_width-1:0] data
);

    logic [inst_width-1:0]     mem [rom_depth];
    logic [xlen-1:0]           offset;
    logic [rom_addr_width-1:0] index;

    initial begin
        $readmemh("program.hex", mem);
    end

    assign offset = addr - rom_base;
    assign index  = offset[rom_addr_width+1:2]; // word index, byte offset dropped

    always_ff @(posedge clk) begin
        if (en) begin
            data <= mem[index]; // holds when not enabled
        end
    end

endmodule

//--- logic/fetch_stage.sv
module fetch_stage
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ds_allowin,
    input  logic [xlen-1:0]       br_alu_target,
    input  logic [1:0]            br_pc_sel,
    input  logic                  br_taken,
    input  logic [xlen-1:0]       br_target,
    input  logic [inst_width-1:0] inst,
    output logic                  fs_to_ds_valid,
    output logic [inst_width-1:0] fs_inst,
    output logic [xlen-1:0]       fs_pc,
    output logic                  i_ram_en,
    output logic [xlen-1:0]       inst_raddr
);

    logic            fs_valid;
    logic            fs_allowin;
    logic            to_fs_valid;
    logic [xlen-1:0] pc_reg;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] wait_jump_pc;
    logic [xlen-1:0] nextpc;

    // pre-IF: next pc generation
    assign to_fs_valid  = ~rst;
    assign seq_pc       = pc_reg + 64'd4;
    assign wait_jump_pc = br_taken ? br_target : seq_pc; // not-taken branch falls through

    always_comb begin
        case (br_pc_sel)
            pc_alu:  nextpc = br_alu_target;
            blu_pc:  nextpc = wait_jump_pc;
            default: nextpc = seq_pc;
        endcase
    end

    // IF stage
    assign fs_allowin     = !fs_valid || ds_allowin; // single-cycle fetch
    assign fs_to_ds_valid = fs_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_reg <= reset_pc;
        end else if (to_fs_valid && fs_allowin) begin
            pc_reg <= nextpc; // pc follows the rom read issued this cycle
        end
    end

    // rom read happens alongside the pc update
    assign i_ram_en   = to_fs_valid && fs_allowin;
    assign inst_raddr = nextpc;

    // wrong-path instruction squashed into a nop at pc 0
    assign fs_inst = br_taken ? nop_inst : inst;
    assign fs_pc   = br_taken ? '0 : pc_reg;

endmodule

//--- logic/frontend_pkg.sv
package frontend_pkg;

    // data path widths
    localparam int xlen       = 64;
    localparam int inst_width = 32;

    // reset value sits one word below the ROM base so the first nextpc is rom_base
    localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_7fff_fffc;
    localparam logic [xlen-1:0] rom_base = 64'h0000_0000_8000_0000;

    // instruction ROM geometry
    localparam int rom_depth      = 64;
    localparam int rom_addr_width = 6;

    localparam logic [inst_width-1:0] nop_inst = 32'h0000_0013; // addi x0,x0,0

    // next-pc select codes
    localparam logic [1:0] pc_pc  = 2'd0; // sequential
    localparam logic [1:0] pc_alu = 2'd1; // jalr target
    localparam logic [1:0] blu_pc = 2'd2; // branch/jal target or fall-through

    // control-flow opcodes
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

endpackage
